// File: hw/decode_issue_pkg.sv
//////////////////////////////////////////////////
// RV32I base encodings only. No M, A, CSR, fence
// or compressed formats are decoded with these.
//////////////////////////////////////////////////
`default_nettype none

package decode_issue_pkg;

    localparam int xlen = 32;
    localparam int pc_offset_width = 21;
    localparam int ls_offset_width = 12;

    //////////////////////////////////////////////////
    // Trimmed opcodes, instruction bits 6 to 2
    typedef logic [4:0] opcode_t;

    localparam opcode_t lui_t = 5'b01101;
    localparam opcode_t auipc_t = 5'b00101;
    localparam opcode_t jal_t = 5'b11011;
    localparam opcode_t jalr_t = 5'b11001;
    localparam opcode_t branch_t = 5'b11000;
    localparam opcode_t load_t = 5'b00000;
    localparam opcode_t store_t = 5'b01000;
    localparam opcode_t arith_imm_t = 5'b00100;
    localparam opcode_t arith_t = 5'b01100;

    //////////////////////////////////////////////////
    // Execution units, one bit each in the unit masks
    localparam int num_units = 3;
    localparam int alu_unit = 0;
    localparam int branch_unit = 1;
    localparam int ls_unit = 2;

    // Function codes
    localparam logic [2:0] add_sub_fn3 = 3'b000;
    localparam logic [2:0] slt_fn3 = 3'b010;
    localparam logic [2:0] sltu_fn3 = 3'b011;
    localparam logic [2:0] xor_fn3 = 3'b100;
    localparam logic [2:0] or_fn3 = 3'b110;
    localparam logic [2:0] and_fn3 = 3'b111;
    localparam logic [2:0] bltu_fn3 = 3'b110;
    localparam logic [2:0] bgeu_fn3 = 3'b111;

    typedef enum logic [1:0] {
        alu_logic_add = 2'b00,
        alu_logic_xor = 2'b01,
        alu_logic_or = 2'b10,
        alu_logic_and = 2'b11
    } alu_logic_op_t;

    //////////////////////////////////////////////////
    // Instruction word views, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] fn3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] fn3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_fields_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] fn3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fields_t;

    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] fn3;
        logic [3:0] imm_4_1;
        logic imm_11;
        logic [6:0] opcode;
    } b_fields_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0] rd;
        logic [6:0] opcode;
    } u_fields_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        s_fields_t s;
        b_fields_t b;
        u_fields_t u;
        j_fields_t j;
    } instr_word_t;

endpackage

`default_nettype wire

// File: hw/unit_select.sv
//////////////////////////////////////////////////
// Purely combinational. Opcodes outside the kept
// RV32I groups need no unit and read no registers.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module unit_select (
    input decode_issue_pkg::instr_word_t instruction,
    output logic [decode_issue_pkg::num_units-1:0] unit_needed,
    output logic uses_rs1,
    output logic uses_rs2
);

    import decode_issue_pkg::*;

    opcode_t opcode_trim;

    assign opcode_trim = instruction.r.opcode[6:2];

    //////////////////////////////////////////////////
    // Unit determination

    // Jumps also write the link address through the ALU
    assign unit_needed[branch_unit] = opcode_trim inside {
        branch_t,
        jal_t,
        jalr_t
    };

    assign unit_needed[alu_unit] = opcode_trim inside {
        arith_t,
        arith_imm_t,
        lui_t,
        auipc_t,
        jal_t,
        jalr_t
    };

    assign unit_needed[ls_unit] = opcode_trim inside {
        load_t,
        store_t
    };

    //////////////////////////////////////////////////
    // Register use

    // LUI, AUIPC and JAL take no rs1
    assign uses_rs1 = opcode_trim inside {
        jalr_t,
        branch_t,
        load_t,
        store_t,
        arith_imm_t,
        arith_t
    };

    // Only R, S and B formats carry rs2
    assign uses_rs2 = opcode_trim inside {
        branch_t,
        store_t,
        arith_t
    };

endmodule

`default_nettype wire

// File: hw/operand_prep.sv
//////////////////////////////////////////////////
// Fields are captured from the decode stage and
// held until the next capture. rs1_data/rs2_data
// must be valid while the instruction waits.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module operand_prep (
    input logic clk,
    input logic rst,
    input logic capture,
    input decode_issue_pkg::instr_word_t instruction,
    input logic [decode_issue_pkg::xlen-1:0] pc,
    input logic [decode_issue_pkg::xlen-1:0] rs1_data,
    input logic [decode_issue_pkg::xlen-1:0] rs2_data,
    output logic [decode_issue_pkg::xlen-1:0] alu_in1,
    output logic [decode_issue_pkg::xlen-1:0] alu_in2,
    output decode_issue_pkg::alu_logic_op_t alu_logic_op,
    output logic alu_subtract,
    output logic alu_slt_path,
    output logic [decode_issue_pkg::pc_offset_width-1:0] br_pc_offset,
    output logic br_jal,
    output logic br_jalr,
    output logic br_use_signed,
    output logic [decode_issue_pkg::ls_offset_width-1:0] ls_offset,
    output logic ls_load,
    output logic ls_store
);

    import decode_issue_pkg::*;

    opcode_t opcode_trim;
    logic [2:0] fn3;
    logic is_jump;
    logic is_upper;
    logic is_arith;
    logic sub_op;

    logic [xlen-1:0] pre_in2;
    logic [xlen-1:0] pre_in1_r;
    logic [xlen-1:0] pre_in2_r;
    logic rs1_use_regfile;
    logic rs2_use_regfile;
    alu_logic_op_t logic_op;
    logic [pc_offset_width-1:0] pc_offset;

    assign opcode_trim = instruction.r.opcode[6:2];
    assign fn3 = instruction.r.fn3;
    assign is_jump = opcode_trim inside {jal_t, jalr_t};
    assign is_upper = opcode_trim inside {lui_t, auipc_t};
    assign is_arith = opcode_trim inside {arith_t, arith_imm_t};

    // funct7 bit 5 marks SUB, only for the register form
    assign sub_op = (opcode_trim == arith_t) && (fn3 == add_sub_fn3) && instruction.r.funct7[5];

    //////////////////////////////////////////////////
    // ALU operands and control

    always_comb begin
        if (is_upper)
            pre_in2 = {instruction.u.imm, 12'b0};
        else if (is_jump)
            pre_in2 = xlen'(4);
        else
            pre_in2 = xlen'(signed'(instruction.i.imm));
    end

    // Anything but plain arithmetic goes through the adder
    always_comb begin
        case (fn3)
            xor_fn3: logic_op = alu_logic_xor;
            or_fn3: logic_op = alu_logic_or;
            and_fn3: logic_op = alu_logic_and;
            default: logic_op = alu_logic_add;
        endcase
        if (!is_arith)
            logic_op = alu_logic_add;
    end

    //////////////////////////////////////////////////
    // Branch target offset, by format
    always_comb begin
        if (opcode_trim == jalr_t)
            pc_offset = pc_offset_width'(signed'(instruction.i.imm));
        else if (opcode_trim == jal_t)
            pc_offset = {instruction.j.imm_20, instruction.j.imm_19_12,
                instruction.j.imm_11, instruction.j.imm_10_1, 1'b0};
        else
            pc_offset = pc_offset_width'(signed'({instruction.b.imm_12,
                instruction.b.imm_11, instruction.b.imm_10_5,
                instruction.b.imm_4_1, 1'b0}));
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (capture) begin
            pre_in1_r <= (opcode_trim == auipc_t || is_jump) ? pc : '0;
            pre_in2_r <= pre_in2;
            br_pc_offset <= pc_offset;
            if (opcode_trim == store_t)
                ls_offset <= {instruction.s.imm_11_5, instruction.s.imm_4_0};
            else
                ls_offset <= instruction.i.imm;
        end
    end

    // Control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            rs1_use_regfile <= 1'b0;
            rs2_use_regfile <= 1'b0;
            alu_logic_op <= alu_logic_add;
            alu_subtract <= 1'b0;
            alu_slt_path <= 1'b0;
            br_jal <= 1'b0;
            br_jalr <= 1'b0;
            br_use_signed <= 1'b0;
            ls_load <= 1'b0;
            ls_store <= 1'b0;
        end else if (capture) begin
            rs1_use_regfile <= !(is_upper || is_jump);
            rs2_use_regfile <= !(is_upper || is_jump || opcode_trim == arith_imm_t);
            alu_logic_op <= logic_op;
            alu_subtract <= sub_op || (is_arith && fn3 inside {slt_fn3, sltu_fn3});
            alu_slt_path <= is_arith && fn3 inside {slt_fn3, sltu_fn3};
            br_jal <= opcode_trim == jal_t;
            br_jalr <= opcode_trim == jalr_t;
            br_use_signed <= !(fn3 inside {bltu_fn3, bgeu_fn3});
            ls_load <= opcode_trim == load_t;
            ls_store <= opcode_trim == store_t;
        end
    end

    //////////////////////////////////////////////////
    // Issue-stage ALU input select
    assign alu_in1 = rs1_use_regfile ? rs1_data : pre_in1_r;
    assign alu_in2 = rs2_use_regfile ? rs2_data : pre_in2_r;

endmodule

`default_nettype wire

// File: hw/issue_control.sv
//////////////////////////////////////////////////
// Single issue-stage slot. A multi-unit op issues
// on any ready unit; flush drops the slot.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module issue_control (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic decode_valid,
    input logic [decode_issue_pkg::num_units-1:0] unit_needed,
    input logic uses_rs1,
    input logic uses_rs2,
    input logic [decode_issue_pkg::num_units-1:0] unit_ready,
    input logic rs1_busy,
    input logic rs2_busy,
    output logic decode_advance,
    output logic [decode_issue_pkg::num_units-1:0] issue_to,
    output logic ls_forward_store
);

    import decode_issue_pkg::*;

    logic stage_valid;
    logic stage_ready;
    logic issue_valid;
    logic [num_units-1:0] unit_needed_r;
    logic uses_rs1_r;
    logic uses_rs2_r;

    logic rs1_conflict;
    logic rs2_conflict;
    logic [num_units-1:0] unit_operands_ready;

    //////////////////////////////////////////////////
    // Stage occupancy

    // Empty, or the current occupant leaves this cycle
    assign stage_ready = ~stage_valid | (|issue_to);
    assign decode_advance = decode_valid & stage_ready;

    always_ff @(posedge clk) begin
        if (rst || flush)
            stage_valid <= 1'b0;
        else if (stage_ready)
            stage_valid <= decode_valid;
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            unit_needed_r <= unit_needed;
            uses_rs1_r <= uses_rs1;
            uses_rs2_r <= uses_rs2;
        end
    end

    //////////////////////////////////////////////////
    // Operand conflicts
    assign rs1_conflict = uses_rs1_r & rs1_busy;
    assign rs2_conflict = uses_rs2_r & rs2_busy;

    // Load-store forwards store data, so it only waits on rs1
    always_comb begin
        unit_operands_ready = {num_units{~rs1_conflict & ~rs2_conflict}};
        unit_operands_ready[ls_unit] = ~rs1_conflict;
    end

    //////////////////////////////////////////////////
    // Issue strobes
    assign issue_valid = stage_valid & ~flush;
    assign issue_to = {num_units{issue_valid}} & unit_needed_r & unit_ready & unit_operands_ready;

    // Store data still in flight when the store goes out
    assign ls_forward_store = issue_to[ls_unit] & rs2_conflict;

endmodule

`default_nettype wire

// File: hw/decode_issue.sv
//////////////////////////////////////////////////
// Decode-and-issue stage, one slot deep. Operand
// outputs are only meaningful with issue_to.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module decode_issue (
    input logic clk,
    input logic rst,
    input logic flush,

    // Decode side
    input logic decode_valid,
    input decode_issue_pkg::instr_word_t decode_instruction,
    input logic [decode_issue_pkg::xlen-1:0] decode_pc,
    output logic decode_advance,

    // Scoreboard and register file
    input logic [decode_issue_pkg::num_units-1:0] unit_ready,
    input logic rs1_busy,
    input logic rs2_busy,
    input logic [decode_issue_pkg::xlen-1:0] rs1_data,
    input logic [decode_issue_pkg::xlen-1:0] rs2_data,

    // Issue side
    output logic [decode_issue_pkg::num_units-1:0] issue_to,
    output logic ls_forward_store,
    output logic [decode_issue_pkg::xlen-1:0] alu_in1,
    output logic [decode_issue_pkg::xlen-1:0] alu_in2,
    output decode_issue_pkg::alu_logic_op_t alu_logic_op,
    output logic alu_subtract,
    output logic alu_slt_path,
    output logic [decode_issue_pkg::pc_offset_width-1:0] br_pc_offset,
    output logic br_jal,
    output logic br_jalr,
    output logic br_use_signed,
    output logic [decode_issue_pkg::ls_offset_width-1:0] ls_offset,
    output logic ls_load,
    output logic ls_store
);

    import decode_issue_pkg::*;

    logic [num_units-1:0] unit_needed;
    logic uses_rs1;
    logic uses_rs2;

    unit_select unit_select_i (
        .instruction(decode_instruction),
        .unit_needed(unit_needed),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2)
    );

    operand_prep operand_prep_i (
        .clk(clk),
        .rst(rst),
        .capture(decode_advance),
        .instruction(decode_instruction),
        .pc(decode_pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .alu_in1(alu_in1),
        .alu_in2(alu_in2),
        .alu_logic_op(alu_logic_op),
        .alu_subtract(alu_subtract),
        .alu_slt_path(alu_slt_path),
        .br_pc_offset(br_pc_offset),
        .br_jal(br_jal),
        .br_jalr(br_jalr),
        .br_use_signed(br_use_signed),
        .ls_offset(ls_offset),
        .ls_load(ls_load),
        .ls_store(ls_store)
    );

    issue_control issue_control_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .decode_valid(decode_valid),
        .unit_needed(unit_needed),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2),
        .unit_ready(unit_ready),
        .rs1_busy(rs1_busy),
        .rs2_busy(rs2_busy),
        .decode_advance(decode_advance),
        .issue_to(issue_to),
        .ls_forward_store(ls_forward_store)
    );

endmodule

`default_nettype wire

// File: verif/decode_issue_properties.sv
//////////////////////////////////////////////////
// Issue strobe rules, bound into decode_issue.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module decode_issue_properties (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic decode_valid,
    input logic decode_advance,
    input logic [decode_issue_pkg::num_units-1:0] issue_to
);

    // Failed assertions so far
    int failures = 0;

    // Flush blocks every strobe
    assert property (@(posedge clk) disable iff (rst) flush |-> (issue_to == '0))
        else begin
            $error("issue_to raised while flush is high");
            failures++;
        end

    // Stage is empty right after reset
    assert property (@(posedge clk) $fell(rst) |-> (issue_to == '0))
        else begin
            $error("issue_to raised in the first cycle after reset");
            failures++;
        end

    // A stalled decode means the occupant is not leaving
    assert property (@(posedge clk) disable iff (rst)
        (decode_valid && !decode_advance) |-> (issue_to == '0))
        else begin
            $error("issue_to raised while decode is stalled");
            failures++;
        end

endmodule

`default_nettype wire

// File: verif/decode_issue_tb.sv
//////////////////////////////////////////////////
// Runs one instruction at a time through the stage.
// Patterns are read from the project root.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module decode_issue_tb;

    import decode_issue_pkg::*;

    localparam int period = 100;
    localparam int drive_delay = 10;
    localparam int reset_cycles = 16;
    localparam int num_patterns = 20;
    localparam int words_per_pattern = 13;
    localparam int timeout_cycles = num_patterns * 10 + reset_cycles;

    logic clk;
    logic rst;
    logic flush;
    logic decode_valid;
    instr_word_t decode_instruction;
    logic [xlen-1:0] decode_pc;
    logic decode_advance;
    logic [num_units-1:0] unit_ready;
    logic rs1_busy;
    logic rs2_busy;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [num_units-1:0] issue_to;
    logic ls_forward_store;
    logic [xlen-1:0] alu_in1;
    logic [xlen-1:0] alu_in2;
    alu_logic_op_t alu_logic_op;
    logic alu_subtract;
    logic alu_slt_path;
    logic [pc_offset_width-1:0] br_pc_offset;
    logic br_jal;
    logic br_jalr;
    logic br_use_signed;
    logic [ls_offset_width-1:0] ls_offset;
    logic ls_load;
    logic ls_store;

    logic [31:0] patterns [0:num_patterns*words_per_pattern-1];
    logic [31:0] rand_state;
    int check_count;
    int error_count;

    decode_issue DUT (.*);

    bind decode_issue decode_issue_properties properties_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .decode_valid(decode_valid),
        .decode_advance(decode_advance),
        .issue_to(issue_to)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(timeout_cycles * period);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // {subtract, slt path, logic op, jal, jalr, signed compare} from the encoding
    function automatic logic [6:0] expected_controls(input logic [31:0] word);
        logic [4:0] opc;
        logic [2:0] f3;
        logic arith;
        logic slt;
        logic sub;
        logic [1:0] lop;
        opc = word[6:2];
        f3 = word[14:12];
        arith = (opc == arith_t) || (opc == arith_imm_t);
        slt = arith && (f3 == slt_fn3 || f3 == sltu_fn3);
        sub = slt || (opc == arith_t && f3 == add_sub_fn3 && word[30]);
        if (arith && f3 == xor_fn3)
            lop = alu_logic_xor;
        else if (arith && f3 == or_fn3)
            lop = alu_logic_or;
        else if (arith && f3 == and_fn3)
            lop = alu_logic_and;
        else
            lop = alu_logic_add;
        return {sub, slt, lop, opc == jal_t, opc == jalr_t, !(f3 == bltu_fn3 || f3 == bgeu_fn3)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_issue(input int base);
        logic [6:0] ctrl;
        logic [31:0] mask;
        ctrl = expected_controls(patterns[base]);
        mask = patterns[base+6];
        check_value("issue_to", mask, 32'(issue_to));
        check_value("ls_forward_store", 32'(patterns[base+4] == 2 && mask[ls_unit]),
            32'(ls_forward_store));
        if (mask[alu_unit]) begin
            check_value("alu_in1", patterns[base+7], alu_in1);
            check_value("alu_in2", patterns[base+8], alu_in2);
            check_value("alu_logic_op", 32'(ctrl[4:3]), 32'(alu_logic_op));
            check_value("alu_subtract", 32'(ctrl[6]), 32'(alu_subtract));
            check_value("alu_slt_path", 32'(ctrl[5]), 32'(alu_slt_path));
        end
        if (mask[branch_unit]) begin
            check_value("br_pc_offset", patterns[base+9], 32'(br_pc_offset));
            check_value("br_jal", 32'(ctrl[2]), 32'(br_jal));
            check_value("br_jalr", 32'(ctrl[1]), 32'(br_jalr));
            if (patterns[base][6:2] == branch_t)
                check_value("br_use_signed", 32'(ctrl[0]), 32'(br_use_signed));
        end
        if (mask[ls_unit])
            check_value("ls_offset", patterns[base+10], 32'(ls_offset));
        check_value("ls_load", patterns[base+11], 32'(ls_load));
        check_value("ls_store", patterns[base+12], 32'(ls_store));
    endtask

    task automatic run_pattern(input int k);
        int base;
        int stall_cycles;
        logic [31:0] mode;
        logic [31:0] mask;
        logic waits;
        logic [xlen-1:0] held_in1;
        logic [xlen-1:0] held_in2;
        base = k * words_per_pattern;
        mode = patterns[base+4];
        mask = patterns[base+6];
        waits = (mode == 1) || (mode == 3) || (mode == 2 && !mask[ls_unit]);
        rand_state = xorshift32(rand_state);
        stall_cycles = 1 + int'(rand_state % 4);

        decode_valid = 1'b1;
        decode_instruction = patterns[base];
        decode_pc = patterns[base+1];
        rs1_data = patterns[base+2];
        rs2_data = patterns[base+3];
        rs1_busy = (mode == 1);
        rs2_busy = (mode == 2);
        unit_ready = (mode == 3) ? ~mask[num_units-1:0] : '1;

        @(negedge clk);
        while (!decode_advance)
            @(negedge clk);
        @(posedge clk);
        #drive_delay;

        if (waits) begin
            for (int i = 0; i < stall_cycles; i++) begin
                @(negedge clk);
                if (i == 0) begin
                    held_in1 = alu_in1;
                    held_in2 = alu_in2;
                end
                check_value("issue_to", 32'(0), 32'(issue_to));
                check_value("decode_advance", 32'(0), 32'(decode_advance));
                check_value("alu_in1", held_in1, alu_in1);
                check_value("alu_in2", held_in2, alu_in2);
                @(posedge clk);
                #drive_delay;
            end
            if (patterns[base+5] != 0) begin
                // Units ready, so only the flush holds the strobe back
                flush = 1'b1;
                decode_valid = 1'b0;
                unit_ready = '1;
                @(negedge clk);
                check_value("issue_to", 32'(0), 32'(issue_to));
                @(posedge clk);
                #drive_delay;
                flush = 1'b0;
                // Dropped instruction must stay gone once the unit is ready
                repeat (2) begin
                    @(negedge clk);
                    check_value("issue_to", 32'(0), 32'(issue_to));
                    @(posedge clk);
                    #drive_delay;
                end
                return;
            end
            rs1_busy = 1'b0;
            rs2_busy = 1'b0;
            unit_ready = '1;
        end
        decode_valid = 1'b0;

        @(negedge clk);
        while (issue_to == '0)
            @(negedge clk);
        check_issue(base);
        @(posedge clk);
        #drive_delay;
        rs1_busy = 1'b0;
        rs2_busy = 1'b0;
        unit_ready = '1;
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        decode_valid = 1'b0;
        decode_instruction = '0;
        decode_pc = '0;
        unit_ready = '1;
        rs1_busy = 1'b0;
        rs2_busy = 1'b0;
        rs1_data = '0;
        rs2_data = '0;
        rand_state = 32'h195;
        check_count = 0;
        error_count = 0;
        $readmemh("verif/decode_issue_patterns.txt", patterns);

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst = 1'b0;

        // Empty stage after reset
        @(negedge clk);
        check_value("issue_to", 32'(0), 32'(issue_to));
        check_value("ls_forward_store", 32'(0), 32'(ls_forward_store));
        check_value("decode_advance", 32'(decode_valid), 32'(decode_advance));
        @(posedge clk);
        #drive_delay;

        for (int k = 0; k < num_patterns; k++)
            run_pattern(k);

        $display("Checks: %0d, value errors: %0d, assertion failures: %0d", check_count,
            error_count, DUT.properties_i.failures);
        if (error_count == 0 && DUT.properties_i.failures == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/decode_issue_patterns.txt
// instr pc rs1_data rs2_data stall flush mask alu_in1 alu_in2 br_offset ls_offset load store
// stall 0 none, 1 rs1 busy, 2 rs2 busy, 3 unit not ready; mask bits alu 1, branch 2, ls 4
002081B3 00000100 11111111 22222222 0 0 1 11111111 22222222 0 0 0 0
407302B3 00000104 00000064 00000003 1 0 1 00000064 00000003 0 0 0 0
003120B3 00000108 FFFFFFFF 00000001 0 0 1 FFFFFFFF 00000001 0 0 0 0
0062B233 0000010C 80000000 7FFFFFFF 2 0 1 80000000 7FFFFFFF 0 0 0 0
FFB10093 00000110 00001000 00000000 1 0 1 00001000 FFFFFFFB 0 0 0 0
7FF24193 00000114 A5A5A5A5 00000000 0 0 1 A5A5A5A5 000007FF 0 0 0 0
123453B7 00000118 DEADBEEF 00000000 3 0 1 00000000 12345000 0 0 0 0
FFFFF417 00400100 DEADBEEF 00000000 0 0 1 00400100 FFFFF000 0 0 0 0
001000EF 00001000 00000000 00000000 0 0 3 00001000 00000004 000800 0 0 0
FFDFF06F 00002000 00000000 00000000 3 0 3 00002000 00000004 1FFFFC 0 0 0
010280E7 00003000 00000200 00000000 1 0 3 00003000 00000004 000010 0 0 0
00208463 00003100 00000005 00000005 2 0 2 00000000 00000000 000008 0 0 0
FE41E8E3 00003200 00000001 00000002 0 0 2 00000000 00000000 1FFFF0 0 0 0
00C32283 00003300 00008000 00000000 1 0 4 00000000 00000000 0 00C 1 0
FFF10083 00003304 00008004 00000000 0 0 4 00000000 00000000 0 FFF 1 0
00742A23 00003308 00009000 CAFEF00D 2 0 4 00000000 00000000 0 014 0 1
FE218023 0000330C 00009100 00000055 3 0 4 00000000 00000000 0 FE0 0 1
00B564B3 00003310 00000003 00000005 3 1 1 00000003 00000005 0 0 0 0
00E6F633 00003314 F0F0F0F0 0FF00FF0 0 0 1 F0F0F0F0 0FF00FF0 0 0 0 0
0FF0F093 00003318 12345678 00000000 0 0 1 12345678 000000FF 0 0 0 0

// File: all.f
hw/decode_issue_pkg.sv
hw/unit_select.sv
hw/operand_prep.sv
hw/issue_control.sv
hw/decode_issue.sv
verif/decode_issue_properties.sv
verif/decode_issue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode/issue testbench with Verilator from the project root.
# Exit status is nonzero unless the pass line is found in the simulation output.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    --top-module decode_issue_tb \
    -f all.f \
    -o sim_decode_issue &&
./obj_dir/sim_decode_issue | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
